// ==== design/fixfl_pkg.sv ====
`default_nettype none

// shared types for the pipelined fixed-point add/multiply unit
package fixfl_pkg;

  // unsigned fixed format, IIIIIIII.FFFFFFFF
  localparam int INT_BITS  = 8;
  localparam int FRAC_BITS = 8;

  localparam int WORD_W = INT_BITS + FRAC_BITS; // operand and result width
  localparam int PROD_W = 2 * WORD_W;           // full product width
  localparam int ADD_W  = WORD_W + 1;           // sum with carry out

  // one operand or one result
  typedef logic [WORD_W-1:0] fixed_t;

  // full product, also used as the running accumulator
  typedef logic [PROD_W-1:0] prod_t;

  // operation select, matches the vector file encoding
  typedef enum logic [0:0]
  {
    OP_ADD = 1'b0,
    OP_MUL = 1'b1
  } fixfl_op_e;

  // item handed from one pipeline register to the next
  // an addition carries its finished sum in acc with mplier at zero,
  // so the multiply stages leave it untouched
  typedef struct packed
  {
    logic      valid;
    fixfl_op_e op;
    prod_t     mcand;  // multiplicand at the weight of mplier bit 0
    fixed_t    mplier; // multiplier bits still to be consumed
    prod_t     acc;    // partial product or zero-extended sum
  } fixfl_item_t;

endpackage

`default_nettype wire

// ==== design/fixfl_launch.sv ====
`default_nettype none

// first pipeline register
// accepts one operation per cycle, finishes an addition here
// and prepares the multiply item for the stage chain
module fixfl_launch
  import fixfl_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire            in_valid, // one strobe per operation
  input  wire fixfl_op_e op,
  input  wire fixed_t    num_a,
  input  wire fixed_t    num_b,
  output fixfl_item_t    item
);

  logic [ADD_W-1:0] sum;       // carry sits in the top bit
  fixfl_item_t      item_next;

  // the whole fixed add is a single adder, no alignment needed
  assign sum = {1'b0, num_a} + {1'b0, num_b};

  always_comb
  begin
    item_next       = '0;
    item_next.valid = in_valid;
    item_next.op    = op;

    // multiplicand starts at bit 0, the finish stage picks the
    // fraction alignment out of the full product
    item_next.mcand = {{(PROD_W-WORD_W){1'b0}}, num_a};

    case (op)
      OP_ADD:
      begin
        // mplier stays zero so every stage adds nothing
        item_next.mplier = '0;
        item_next.acc    = {{(PROD_W-ADD_W){1'b0}}, sum};
      end
      OP_MUL:
      begin
        item_next.mplier = num_b;
        item_next.acc    = '0; // empty accumulator
      end
      default:
      begin
        item_next.mplier = '0;
        item_next.acc    = '0;
      end
    endcase
  end

  // payload loads every cycle, only valid sees reset
  always_ff @(posedge clk)
  begin
    item <= item_next;
    if (reset)
    begin
      item.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/fixfl_mul_stage.sv ====
`default_nettype none

// one step of the shift-and-add multiplier
// consumes BITS_PER_STAGE multiplier bits per cycle
module fixfl_mul_stage
  import fixfl_pkg::*;
#(
  parameter int BITS_PER_STAGE = 4 // must divide WORD_W
)
(
  input  wire              clk,
  input  wire              reset,
  input  wire fixfl_item_t item_in,
  output fixfl_item_t      item_out
);

  prod_t       pp [BITS_PER_STAGE]; // gated partial products of this slice
  prod_t       acc_sum;
  fixfl_item_t item_next;

  // each multiplier bit enables one shifted copy of the multiplicand
  always_comb
  begin
    for (int i = 0; i < BITS_PER_STAGE; i++)
    begin
      pp[i] = (item_in.mcand << i) & {PROD_W{item_in.mplier[i]}};
    end
  end

  // fold the slice into the running product
  always_comb
  begin
    acc_sum = item_in.acc;
    for (int i = 0; i < BITS_PER_STAGE; i++)
    begin
      acc_sum = acc_sum + pp[i];
    end
  end

  // advance the weights for the next stage
  always_comb
  begin
    item_next = item_in;
    item_next.acc = acc_sum;

    // multiplicand moves up by the bits consumed here
    item_next.mcand = item_in.mcand << BITS_PER_STAGE;

    // used bits drop out, the next slice lands at bit 0
    item_next.mplier = item_in.mplier >> BITS_PER_STAGE;
  end

  // an add item has mplier at zero and passes through unchanged,
  // so op is never looked at here
  always_ff @(posedge clk)
  begin
    item_out <= item_next;
    if (reset)
    begin
      item_out.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/fixfl_finish.sv ====
`default_nettype none

// last pipeline register
// slices the fixed result out of the accumulator and sets the flags
module fixfl_finish
  import fixfl_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire fixfl_item_t item,
  output logic             out_valid, // one pulse per result
  output fixed_t           result,
  output logic             overflow,
  output logic             precision_lost
);

  fixed_t res_next;
  logic   ovf_next;
  logic   lost_next;

  always_comb
  begin
    res_next  = '0;
    ovf_next  = 1'b0;
    lost_next = 1'b0;

    case (item.op)
      OP_ADD:
      begin
        // sum is already in fixed format, carry is the overflow
        res_next  = item.acc[WORD_W-1:0];
        ovf_next  = item.acc[WORD_W];
        lost_next = 1'b0; // addition is exact
      end
      OP_MUL:
      begin
        // product has 2*FRAC_BITS fraction bits, drop the lower half
        res_next = item.acc[FRAC_BITS +: WORD_W];

        // anything above the integer field does not fit
        ovf_next = |item.acc[PROD_W-1 -: INT_BITS];

        // truncated fraction bits
        lost_next = |item.acc[FRAC_BITS-1:0];
      end
      default:
      begin
        res_next  = '0;
        ovf_next  = 1'b0;
        lost_next = 1'b0;
      end
    endcase
  end

  // result and flags registered, out_valid cleared by reset
  always_ff @(posedge clk)
  begin
    result         <= res_next;
    overflow       <= ovf_next;
    precision_lost <= lost_next;

    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= item.valid;
    end
  end

endmodule

`default_nettype wire

// ==== design/fixfl_unit.sv ====
`default_nettype none

// pipelined 16-bit unsigned fixed-point add/multiply unit
//
// one operation may enter every cycle, results leave in order
// latency is NUM_STAGES+2 cycles from the in_valid edge:
// launch register, NUM_STAGES multiply steps, finish register
module fixfl_unit
  import fixfl_pkg::*;
#(
  parameter int BITS_PER_STAGE = 4 // multiplier bits per stage
)
(
  input  wire            clk,
  input  wire            reset,

  // operation in, no back-pressure
  input  wire            in_valid,
  input  wire fixfl_op_e op,
  input  wire fixed_t    num_a, // multiplicand for OP_MUL
  input  wire fixed_t    num_b, // multiplier for OP_MUL

  // result out, held for a single cycle
  output logic           out_valid,
  output fixed_t         result,
  output logic           overflow,
  output logic           precision_lost
);

  localparam int NUM_STAGES = WORD_W / BITS_PER_STAGE;

  // pipe[0] from launch, pipe[k+1] from stage k, last one to finish
  fixfl_item_t pipe [NUM_STAGES+1];

  fixfl_launch u_launch
  (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .op       (op),
    .num_a    (num_a),
    .num_b    (num_b),
    .item     (pipe[0])
  );

  // shift-and-add chain, one slice of the multiplier per stage
  for (genvar k = 0; k < NUM_STAGES; k++)
  begin : g_stage
    fixfl_mul_stage
    #(
      .BITS_PER_STAGE (BITS_PER_STAGE)
    )
    u_stage
    (
      .clk      (clk),
      .reset    (reset),
      .item_in  (pipe[k]),
      .item_out (pipe[k+1])
    );
  end

  fixfl_finish u_finish
  (
    .clk            (clk),
    .reset          (reset),
    .item           (pipe[NUM_STAGES]),
    .out_valid      (out_valid),
    .result         (result),
    .overflow       (overflow),
    .precision_lost (precision_lost)
  );

endmodule

`default_nettype wire

// ==== sim/fixfl_unit_tb.sv ====
`default_nettype none

// testbench for the pipelined fixed-point unit, vectors from sim/fixfl_input.txt
module fixfl_unit_tb
  import fixfl_pkg::*;
;

  localparam int BITS_PER_STAGE = 4;
  localparam int LATENCY        = WORD_W / BITS_PER_STAGE + 2; // launch, stages, finish
  localparam int DRAIN_LIMIT    = 50;

  typedef struct packed
  {
    logic   op;
    fixed_t a;
    fixed_t b;
    fixed_t res;
    logic   ovf;
    logic   lost;
  } vec_t;

  typedef struct packed
  {
    fixed_t      res;
    logic        ovf;
    logic        lost;
    logic [31:0] issue_cycle; // cycle in which in_valid is high
  } exp_t;

  logic      clk;
  logic      reset;
  logic      in_valid;
  fixfl_op_e op;
  fixed_t    num_a;
  fixed_t    num_b;
  logic      out_valid;
  fixed_t    result;
  logic      overflow;
  logic      precision_lost;

  logic [31:0] cycle = '0;
  int          mismatches = 0;
  int          failures = 0;
  int          strobes = 0;
  int          results = 0;
  exp_t        exp_q [$];
  exp_t        got;

  fixfl_unit
  #(
    .BITS_PER_STAGE (BITS_PER_STAGE)
  )
  uut
  (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .op             (op),
    .num_a          (num_a),
    .num_b          (num_b),
    .out_valid      (out_valid),
    .result         (result),
    .overflow       (overflow),
    .precision_lost (precision_lost)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      mismatches++;
      $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
    end
  endtask

  // called 2 units after a rising edge, returns at the same point one cycle later
  task automatic issue(input vec_t v);
    exp_t e;
    in_valid = 1'b1;
    op       = fixfl_op_e'(v.op);
    num_a    = v.a;
    num_b    = v.b;
    e.res         = v.res;
    e.ovf         = v.ovf;
    e.lost        = v.lost;
    e.issue_cycle = cycle;
    exp_q.push_back(e);
    strobes++;
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  // results are checked in the middle of the cycle
  always @(negedge clk)
  begin
    if (reset)
    begin
      if (cycle > 0)
        check_equal(out_valid, 1'b0, "out_valid during reset");
    end
    else if (out_valid === 1'b1)
    begin
      results++; // every pulse, expected or not
      if (exp_q.size() == 0)
      begin
        failures++;
        $display("unexpected result at %0t with no operation pending", $time);
      end
      else
      begin
        got = exp_q.pop_front();
        check_equal(result, got.res, $sformatf("result of item %0d", results));
        check_equal(overflow, got.ovf, $sformatf("overflow of item %0d", results));
        check_equal(precision_lost, got.lost, $sformatf("precision_lost of item %0d", results));
        check_equal(cycle - got.issue_cycle, LATENCY, $sformatf("latency of item %0d", results));
      end
    end
    else if (out_valid !== 1'b0)
    begin
      failures++;
      $display("out_valid is unknown at %0t", $time);
    end
  end

  initial
  begin
    int          fd;
    int          n;
    int          waited;
    string       line;
    logic [31:0] t_op, t_a, t_b, t_r, t_o, t_l;
    logic [31:0] lfsr;
    logic [1:0]  gap;
    vec_t        v;
    vec_t        vecs [$];
    vec_t        add_q [$];
    vec_t        mul_q [$];

    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    op       = OP_ADD;
    num_a    = '0;
    num_b    = '0;
    lfsr     = 32'he632883e;

    fd = $fopen("sim/fixfl_input.txt", "r");
    if (fd == 0)
    begin
      failures++;
      $display("could not open the vector file sim/fixfl_input.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h %h", t_op, t_a, t_b, t_r, t_o, t_l);
        if (n == 6) // comment and blank lines give fewer fields
        begin
          v = '{op: t_op[0], a: t_a[15:0], b: t_b[15:0], res: t_r[15:0],
                ovf: t_o[0], lost: t_l[0]};
          vecs.push_back(v);
          if (v.op)
            mul_q.push_back(v);
          else
            add_q.push_back(v);
        end
      end
      $fclose(fd);
    end

    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    repeat (4) @(posedge clk); // idle, nothing may come out
    #2;

    // file order with random idle gaps
    foreach (vecs[i])
    begin
      issue(vecs[i]);
      lfsr   = lfsr_next(lfsr);
      gap[0] = lfsr[0];
      lfsr   = lfsr_next(lfsr);
      gap[1] = lfsr[0];
      repeat (gap)
      begin
        @(posedge clk);
        #2;
      end
    end

    // back to back, add and mul alternating
    for (int i = 0; i < add_q.size() || i < mul_q.size(); i++)
    begin
      if (i < add_q.size())
        issue(add_q[i]);
      if (i < mul_q.size())
        issue(mul_q[i]);
    end

    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      failures++;
      $display("timeout: %0d results missing", exp_q.size());
    end

    repeat (LATENCY + 2) @(posedge clk); // catch stray pulses
    check_equal(results, strobes, "number of results");

    $display("errors: %0d mismatches, %0d other failures (%0d strobes, %0d results)",
             mismatches, failures, strobes, results);
    if (mismatches == 0 && failures == 0 && strobes > 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/fixfl_input.txt ====
# op a b result overflow precision_lost, all hex
# op 0 is add, op 1 is mul
0 0100 0200 0300 0 0
1 0100 0100 0100 0 0
0 0080 0080 0100 0 0
1 0200 0300 0600 0 0
0 ff00 0100 0000 1 0
1 0180 0200 0300 0 0
0 ffff 0001 0000 1 0
1 0080 0080 0040 0 0
0 8000 8001 0001 1 0
1 0001 0001 0000 0 1
0 1234 4321 5555 0 0
1 0003 0081 0001 0 1
0 0000 0000 0000 0 0
1 0155 0003 0003 0 1
0 fedc 0123 ffff 0 0
1 1000 1000 0000 1 0
0 abcd 9876 4443 1 0
1 ffff ffff fe00 1 1
1 0000 1234 0000 0 0
1 abcd 0000 0000 0 0
1 0f00 0f00 e100 0 0
1 0f00 1100 ff00 0 0
1 1000 1001 0010 1 0
1 0123 0456 04ed 0 1

// ==== sources.f ====
design/fixfl_pkg.sv
design/fixfl_launch.sv
design/fixfl_mul_stage.sv
design/fixfl_finish.sv
design/fixfl_unit.sv
sim/fixfl_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fixfl_unit

sources:
  - design/fixfl_pkg.sv
  - design/fixfl_launch.sv
  - design/fixfl_mul_stage.sv
  - design/fixfl_finish.sv
  - design/fixfl_unit.sv
  - target: simulation
    files:
      - sim/fixfl_unit_tb.sv
